/* dcache_ctrl.sv */
module dcache_ctrl #(
    parameter int INDEX_W = 4
) (
    input  logic               clk,
    input  logic               rst,
    input  logic               cpu_req,
    input  logic               cpu_we,
    input  dcache_pkg::addr_t  cpu_addr,
    output dcache_pkg::word_t  cpu_rdata,
    output logic               cpu_ready,
    input  logic               hit,
    input  dcache_pkg::way_e   hit_way,
    input  dcache_pkg::way_e   victim_way,
    input  logic               victim_dirty,
    input  dcache_pkg::addr_t  victim_addr,
    input  dcache_pkg::line_t  victim_line,
    input  dcache_pkg::word_t  rd_word,
    output logic               tag_we,
    output dcache_pkg::way_e   tag_way,
    output logic               set_dirty,
    output logic               touch,
    output logic               word_we,
    output logic               line_we,
    output dcache_pkg::line_t  fill_line,
    output dcache_pkg::way_e   data_way,
    l2_xfer_if.ctrl            l2
);

    localparam int TAG_W = dcache_pkg::ADDR_W - INDEX_W - dcache_pkg::LINE_OFS_W;

    dcache_pkg::ctrl_state_e state;
    dcache_pkg::ctrl_state_e next_state;
    dcache_pkg::addr_t       refill_addr;

    // line address of the cpu access
    assign refill_addr = {cpu_addr[dcache_pkg::ADDR_W-1 -: TAG_W],
                          cpu_addr[dcache_pkg::LINE_OFS_W +: INDEX_W],
                          {dcache_pkg::LINE_OFS_W{1'b0}}};

    assign cpu_ready = (state == dcache_pkg::RESPOND);
    assign fill_line = l2.rline;
    assign tag_way   = victim_way;  // tags only written on refill
    assign data_way  = (state == dcache_pkg::REFILL) ? victim_way : hit_way;
    assign l2.wline  = victim_line;

    always_comb begin
        next_state  = state;
        l2.start    = 1'b0;
        l2.is_write = 1'b0;
        l2.addr     = refill_addr;
        tag_we      = 1'b0;
        set_dirty   = 1'b0;
        touch       = 1'b0;
        word_we     = 1'b0;
        line_we     = 1'b0;
        case (state)
            dcache_pkg::IDLE: begin
                if (cpu_req) begin
                    next_state = dcache_pkg::LOOKUP;
                end
            end
            dcache_pkg::LOOKUP: begin
                if (hit) begin
                    word_we    = cpu_we;
                    set_dirty  = cpu_we;
                    touch      = 1'b1;
                    next_state = dcache_pkg::RESPOND;
                end else if (victim_dirty) begin
                    // victim goes back to l2 first
                    l2.start    = 1'b1;
                    l2.is_write = 1'b1;
                    l2.addr     = victim_addr;
                    next_state  = dcache_pkg::WRITEBACK;
                end else begin
                    l2.start   = 1'b1;
                    next_state = dcache_pkg::REFILL;
                end
            end
            dcache_pkg::WRITEBACK: begin
                if (l2.done) begin
                    l2.start   = 1'b1;       // port is idle again
                    next_state = dcache_pkg::REFILL;
                end
            end
            dcache_pkg::REFILL: begin
                if (l2.done) begin
                    tag_we     = 1'b1;
                    line_we    = 1'b1;
                    next_state = dcache_pkg::LOOKUP;  // finishes as a hit
                end
            end
            dcache_pkg::RESPOND: begin
                next_state = dcache_pkg::IDLE;
            end
            default: begin
                next_state = dcache_pkg::IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= dcache_pkg::IDLE;
        end else begin
            state <= next_state;
        end
    end

    // read data for the respond cycle
    always_ff @(posedge clk) begin
        if (state == dcache_pkg::LOOKUP && hit && !cpu_we) begin
            cpu_rdata <= rd_word;
        end
    end

endmodule

/* dcache_data_store.sv */
module dcache_data_store #(
    parameter int INDEX_W = 4
) (
    input  logic               clk,
    input  dcache_pkg::addr_t  addr,
    input  dcache_pkg::way_e   way,
    input  logic               word_we,
    input  dcache_pkg::word_t  wdata,
    input  logic               line_we,
    input  dcache_pkg::line_t  fill_line,
    input  dcache_pkg::way_e   victim_way,
    output dcache_pkg::word_t  rd_word,
    output dcache_pkg::line_t  victim_line
);

    localparam int SETS  = 1 << INDEX_W;
    localparam int SEL_W = $clog2(dcache_pkg::WORDS_PER_LINE);

    dcache_pkg::line_t lines [2][SETS];

    logic [INDEX_W-1:0] idx;
    logic [SEL_W-1:0]   word_sel;
    dcache_pkg::line_t  sel_line;

    assign idx      = addr[dcache_pkg::LINE_OFS_W +: INDEX_W];
    assign word_sel = addr[2 +: SEL_W];         // bits 3:2

    // whole line on refill, else one word
    always_ff @(posedge clk) begin
        if (line_we) begin
            lines[way][idx] <= fill_line;
        end else if (word_we) begin
            lines[way][idx][word_sel*dcache_pkg::WORD_W +: dcache_pkg::WORD_W] <= wdata;
        end
    end

    // combinational reads
    assign sel_line    = lines[way][idx];
    assign rd_word     = sel_line[word_sel*dcache_pkg::WORD_W +: dcache_pkg::WORD_W];
    assign victim_line = lines[victim_way][idx];

endmodule

/* dcache_l2_port.sv */
module dcache_l2_port (
    input  logic               clk,
    input  logic               rst,
    l2_xfer_if.port            xfer,
    output logic               l2_req,
    output logic               l2_we,
    output dcache_pkg::addr_t  l2_addr,
    output dcache_pkg::line_t  l2_wdata,
    input  dcache_pkg::line_t  l2_rdata,
    input  logic               l2_ack
);

    typedef enum logic [1:0] {
        P_IDLE    = 2'd0,
        P_REQ     = 2'd1,   // req high, waiting for ack
        P_RELEASE = 2'd2    // req low, waiting for ack to fall
    } port_state_e;

    port_state_e state;

    // four-phase sequencer
    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= P_IDLE;
            l2_req    <= 1'b0;
            xfer.done <= 1'b0;
        end else begin
            xfer.done <= 1'b0;
            case (state)
                P_IDLE: begin
                    if (xfer.start) begin
                        l2_req <= 1'b1;
                        state  <= P_REQ;
                    end
                end
                P_REQ: begin
                    if (l2_ack) begin
                        l2_req <= 1'b0;
                        state  <= P_RELEASE;
                    end
                end
                P_RELEASE: begin
                    if (!l2_ack) begin
                        xfer.done <= 1'b1;
                        state     <= P_IDLE;
                    end
                end
                default: begin
                    state <= P_IDLE;
                end
            endcase
        end
    end

    // line buffer, held for the whole request
    always_ff @(posedge clk) begin
        if (state == P_IDLE && xfer.start) begin
            l2_we    <= xfer.is_write;
            l2_addr  <= xfer.addr;
            l2_wdata <= xfer.wline;
        end
    end

    // refill data taken at ack
    always_ff @(posedge clk) begin
        if (state == P_REQ && l2_ack && !l2_we) begin
            xfer.rline <= l2_rdata;
        end
    end

endmodule

/* dcache_pkg.sv */
package dcache_pkg;

    // address and data widths
    localparam int ADDR_W         = 32;
    localparam int WORD_W         = 32;
    localparam int LINE_W         = 128;
    localparam int WORDS_PER_LINE = 4;
    localparam int LINE_OFS_W     = 4;    // byte offset inside a line

    typedef logic [ADDR_W-1:0] addr_t;    // byte address
    typedef logic [WORD_W-1:0] word_t;    // one cpu word
    typedef logic [LINE_W-1:0] line_t;    // word 0 in the low bits

    // cache way
    typedef enum logic {
        WAY0 = 1'b0,
        WAY1 = 1'b1
    } way_e;

    // controller states
    typedef enum logic [2:0] {
        IDLE      = 3'd0,
        LOOKUP    = 3'd1,
        WRITEBACK = 3'd2,
        REFILL    = 3'd3,
        RESPOND   = 3'd4
    } ctrl_state_e;

endpackage

/* dcache_tag_store.sv */
module dcache_tag_store #(
    parameter int INDEX_W = 4
) (
    input  logic               clk,
    input  logic               rst,
    input  dcache_pkg::addr_t  addr,
    input  logic               tag_we,
    input  dcache_pkg::way_e   tag_way,
    input  logic               set_dirty,
    input  logic               touch,
    output logic               hit,
    output dcache_pkg::way_e   hit_way,
    output dcache_pkg::way_e   victim_way,
    output logic               victim_dirty,
    output dcache_pkg::addr_t  victim_addr
);

    localparam int TAG_W = dcache_pkg::ADDR_W - INDEX_W - dcache_pkg::LINE_OFS_W;
    localparam int SETS  = 1 << INDEX_W;

    logic [TAG_W-1:0] tags [2][SETS];
    logic [SETS-1:0]  valid [2];
    logic [SETS-1:0]  dirty [2];
    logic [SETS-1:0]  lru;              // names the way to replace next

    logic [INDEX_W-1:0] idx;
    logic [TAG_W-1:0]   addr_tag;
    logic               hit0;
    logic               hit1;

    assign idx      = addr[dcache_pkg::LINE_OFS_W +: INDEX_W];
    assign addr_tag = addr[dcache_pkg::ADDR_W-1 -: TAG_W];

    // tag compare on both ways
    assign hit0    = valid[0][idx] && (tags[0][idx] == addr_tag);
    assign hit1    = valid[1][idx] && (tags[1][idx] == addr_tag);
    assign hit     = hit0 || hit1;
    assign hit_way = hit0 ? dcache_pkg::WAY0 : dcache_pkg::WAY1;

    // invalid way first, then lru
    always_comb begin
        if (!valid[0][idx]) begin
            victim_way = dcache_pkg::WAY0;
        end else if (!valid[1][idx]) begin
            victim_way = dcache_pkg::WAY1;
        end else begin
            victim_way = dcache_pkg::way_e'(lru[idx]);
        end
    end

    assign victim_dirty = valid[victim_way][idx] && dirty[victim_way][idx];
    assign victim_addr  = {tags[victim_way][idx], idx, {dcache_pkg::LINE_OFS_W{1'b0}}};

    // tag array
    always_ff @(posedge clk) begin
        if (tag_we) begin
            tags[tag_way][idx] <= addr_tag;
        end
    end

    // line state bits
    always_ff @(posedge clk) begin
        if (rst) begin
            valid[0] <= '0;
            valid[1] <= '0;
            dirty[0] <= '0;
            dirty[1] <= '0;
            lru      <= '0;
        end else begin
            if (tag_we) begin               // fresh line from l2
                valid[tag_way][idx] <= 1'b1;
                dirty[tag_way][idx] <= 1'b0;
            end
            if (set_dirty) begin
                dirty[hit_way][idx] <= 1'b1;
            end
            if (touch) begin
                // the other way becomes the next victim
                lru[idx] <= (hit_way == dcache_pkg::WAY0);
            end
        end
    end

endmodule

/* dcache_top.sv */
module dcache_top #(
    parameter int INDEX_W = 4
) (
    input  logic               clk,
    input  logic               rst,
    input  logic               cpu_req,
    input  logic               cpu_we,
    input  dcache_pkg::addr_t  cpu_addr,
    input  dcache_pkg::word_t  cpu_wdata,
    output dcache_pkg::word_t  cpu_rdata,
    output logic               cpu_ready,
    output logic               l2_req,
    output logic               l2_we,
    output dcache_pkg::addr_t  l2_addr,
    output dcache_pkg::line_t  l2_wdata,
    input  dcache_pkg::line_t  l2_rdata,
    input  logic               l2_ack
);

    logic              hit;
    dcache_pkg::way_e  hit_way;
    dcache_pkg::way_e  victim_way;
    logic              victim_dirty;
    dcache_pkg::addr_t victim_addr;
    dcache_pkg::line_t victim_line;
    dcache_pkg::word_t rd_word;
    logic              tag_we;
    dcache_pkg::way_e  tag_way;
    logic              set_dirty;
    logic              touch;
    logic              word_we;
    logic              line_we;
    dcache_pkg::line_t fill_line;
    dcache_pkg::way_e  data_way;

    l2_xfer_if xfer ();

    dcache_tag_store #(
        .INDEX_W (INDEX_W)
    ) dcache_tag_store_inst (
        .clk          (clk),
        .rst          (rst),
        .addr         (cpu_addr),
        .tag_we       (tag_we),
        .tag_way      (tag_way),
        .set_dirty    (set_dirty),
        .touch        (touch),
        .hit          (hit),
        .hit_way      (hit_way),
        .victim_way   (victim_way),
        .victim_dirty (victim_dirty),
        .victim_addr  (victim_addr)
    );

    dcache_data_store #(
        .INDEX_W (INDEX_W)
    ) dcache_data_store_inst (
        .clk         (clk),
        .addr        (cpu_addr),
        .way         (data_way),
        .word_we     (word_we),
        .wdata       (cpu_wdata),
        .line_we     (line_we),
        .fill_line   (fill_line),
        .victim_way  (victim_way),
        .rd_word     (rd_word),
        .victim_line (victim_line)
    );

    dcache_ctrl #(
        .INDEX_W (INDEX_W)
    ) dcache_ctrl_inst (
        .clk          (clk),
        .rst          (rst),
        .cpu_req      (cpu_req),
        .cpu_we       (cpu_we),
        .cpu_addr     (cpu_addr),
        .cpu_rdata    (cpu_rdata),
        .cpu_ready    (cpu_ready),
        .hit          (hit),
        .hit_way      (hit_way),
        .victim_way   (victim_way),
        .victim_dirty (victim_dirty),
        .victim_addr  (victim_addr),
        .victim_line  (victim_line),
        .rd_word      (rd_word),
        .tag_we       (tag_we),
        .tag_way      (tag_way),
        .set_dirty    (set_dirty),
        .touch        (touch),
        .word_we      (word_we),
        .line_we      (line_we),
        .fill_line    (fill_line),
        .data_way     (data_way),
        .l2           (xfer)
    );

    dcache_l2_port dcache_l2_port_inst (
        .clk      (clk),
        .rst      (rst),
        .xfer     (xfer),
        .l2_req   (l2_req),
        .l2_we    (l2_we),
        .l2_addr  (l2_addr),
        .l2_wdata (l2_wdata),
        .l2_rdata (l2_rdata),
        .l2_ack   (l2_ack)
    );

endmodule

/* l2_xfer_if.sv */
interface l2_xfer_if;

    logic               start;     // one cycle, opens a transfer
    logic               is_write;  // write-back when set, refill otherwise
    dcache_pkg::addr_t  addr;      // line aligned
    dcache_pkg::line_t  wline;     // victim line for a write-back
    logic               done;      // one cycle, handshake back at idle
    dcache_pkg::line_t  rline;     // refill data, held after done

    // cache controller side
    modport ctrl (
        output start,
        output is_write,
        output addr,
        output wline,
        input  done,
        input  rline
    );

    // l2 port side
    modport port (
        input  start,
        input  is_write,
        input  addr,
        input  wline,
        output done,
        output rline
    );

endinterface

/* tb.f */
dcache_pkg.sv
l2_xfer_if.sv
dcache_tag_store.sv
dcache_data_store.sv
dcache_ctrl.sv
dcache_l2_port.sv
dcache_top.sv
tb_clock_gen.sv
tb_l2_model.sv
tb_dcache.sv

/* tb_clock_gen.sv */
module tb_clock_gen (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;      // period 8
    end

    // reset held for 4 cycles, released on a falling edge
    initial begin
        rst = 1'b1;
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
    end

endmodule

/* tb_dcache.sv */
module tb_dcache;

    localparam int READY_LIMIT = 200;
    localparam int RESET_LIMIT = 20;

    logic              clk;
    logic              rst;
    logic              cpu_req;
    logic              cpu_we;
    dcache_pkg::addr_t cpu_addr;
    dcache_pkg::word_t cpu_wdata;
    dcache_pkg::word_t cpu_rdata;
    logic              cpu_ready;
    logic              l2_req;
    logic              l2_we;
    dcache_pkg::addr_t l2_addr;
    dcache_pkg::line_t l2_wdata;
    dcache_pkg::line_t l2_rdata;
    logic              l2_ack;
    int                wb_count;
    dcache_pkg::addr_t last_wb_addr;
    int                model_errors;

    dcache_pkg::word_t shadow [dcache_pkg::addr_t];   // completed cpu writes
    logic              cur_we;
    dcache_pkg::addr_t cur_addr;
    dcache_pkg::word_t cur_wdata;
    int                checks;
    int                errors;
    int                timeouts;
    int                req_count;
    logic              prev_req;
    logic              prev_ack;
    logic              held_we;
    dcache_pkg::addr_t held_addr;
    dcache_pkg::line_t held_wdata;
    logic [31:0]       lfsr_state;

    tb_clock_gen tb_clock_gen_inst (
        .clk (clk),
        .rst (rst)
    );

    dcache_top #(
        .INDEX_W (4)
    ) dcache_top_inst (
        .clk       (clk),
        .rst       (rst),
        .cpu_req   (cpu_req),
        .cpu_we    (cpu_we),
        .cpu_addr  (cpu_addr),
        .cpu_wdata (cpu_wdata),
        .cpu_rdata (cpu_rdata),
        .cpu_ready (cpu_ready),
        .l2_req    (l2_req),
        .l2_we     (l2_we),
        .l2_addr   (l2_addr),
        .l2_wdata  (l2_wdata),
        .l2_rdata  (l2_rdata),
        .l2_ack    (l2_ack)
    );

    tb_l2_model tb_l2_model_inst (
        .clk          (clk),
        .l2_req       (l2_req),
        .l2_we        (l2_we),
        .l2_addr      (l2_addr),
        .l2_wdata     (l2_wdata),
        .l2_rdata     (l2_rdata),
        .l2_ack       (l2_ack),
        .wb_count     (wb_count),
        .last_wb_addr (last_wb_addr),
        .model_errors (model_errors)
    );

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    task automatic rand_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            v          = {v[30:0], lfsr_state[0]};
            lfsr_state = lfsr_next(lfsr_state);
        end
    endtask

    // last written value, else the l2 start pattern
    function automatic dcache_pkg::word_t expected_word(input dcache_pkg::addr_t a);
        if (shadow.exists(a)) begin
            return shadow[a];
        end
        return {16'h5A5A, a[31:16] ^ a[15:0]};
    endfunction

    task automatic end_run();
        $display("checks %0d, errors %0d, timeouts %0d, l2 model errors %0d",
                 checks, errors, timeouts, model_errors);
        if (errors == 0 && timeouts == 0 && model_errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    endtask

    // one cpu access, returns falling edges until cpu_ready
    task automatic cpu_access(input logic we, input dcache_pkg::addr_t addr,
                              input dcache_pkg::word_t wdata, output int cycles);
        @(negedge clk);
        cur_we    = we;
        cur_addr  = addr;
        cur_wdata = wdata;
        cpu_we    = we;
        cpu_addr  = addr;
        cpu_wdata = wdata;
        cpu_req   = 1'b1;
        @(negedge clk);
        cycles = 1;
        while (!cpu_ready && cycles < READY_LIMIT) begin
            @(negedge clk);
            cycles++;
        end
        if (!cpu_ready) begin
            $display("timeout waiting for cpu_ready at %0t, address %h", $time, addr);
            timeouts++;
            end_run();
        end else begin
            cpu_req = 1'b0;
        end
    endtask

    // compares each read against the reference
    always @(negedge clk) begin
        if (cpu_ready) begin
            if (cur_we) begin
                shadow[cur_addr] = cur_wdata;
            end else begin
                checks++;
                if (cpu_rdata !== expected_word(cur_addr)) begin
                    errors++;
                    $display("Error at %0t: read %h returned %h, expected %h",
                             $time, cur_addr, cpu_rdata, expected_word(cur_addr));
                end
            end
        end
    end

    // l2 handshake rules, sampled at the active edge
    always @(posedge clk) begin
        if (!rst) begin
            if (l2_req && !prev_req) begin
                req_count++;
                if (l2_addr[3:0] !== 4'h0) begin
                    errors++;
                    $display("Error at %0t: l2_addr %h not line aligned", $time, l2_addr);
                end
            end
            if (l2_req && prev_req && (l2_addr !== held_addr || l2_we !== held_we ||
                                       l2_wdata !== held_wdata)) begin
                errors++;
                $display("Error at %0t: l2 request changed while l2_req was high", $time);
            end
            if (!l2_req && prev_req && !prev_ack) begin
                errors++;
                $display("Error at %0t: l2_req fell before l2_ack was high", $time);
            end
        end
        prev_req   = l2_req;
        prev_ack   = l2_ack;
        held_we    = l2_we;
        held_addr  = l2_addr;
        held_wdata = l2_wdata;
    end

    initial begin
        int                cycles;
        int                n;
        int                req_before;
        int                wb_before;
        logic [31:0]       r_tag;
        logic [31:0]       r_set;
        logic [31:0]       r_word;
        logic [31:0]       r_we;
        logic [31:0]       r_data;
        dcache_pkg::addr_t a;
        cpu_req    = 1'b0;
        cpu_we     = 1'b0;
        cpu_addr   = '0;
        cpu_wdata  = '0;
        cur_we     = 1'b0;
        cur_addr   = '0;
        cur_wdata  = '0;
        checks     = 0;
        errors     = 0;
        timeouts   = 0;
        req_count  = 0;
        prev_req   = 1'b0;
        prev_ack   = 1'b0;
        lfsr_state = 32'ha476a1d7;

        n = 0;
        while (rst !== 1'b0 && n < RESET_LIMIT) begin
            @(posedge clk);
            n++;
        end
        if (rst !== 1'b0) begin
            $display("timeout waiting for reset to end");
            timeouts++;
            end_run();
        end

        // quiet after reset
        repeat (5) begin
            @(negedge clk);
            if (cpu_ready !== 1'b0 || l2_req !== 1'b0) begin
                errors++;
                $display("Error at %0t: cpu_ready %b l2_req %b while idle",
                         $time, cpu_ready, l2_req);
            end
        end

        // read miss, then a hit in the same line
        req_before = req_count;
        cpu_access(1'b0, 32'h0000_0044, '0, cycles);
        if (req_count != req_before + 1) begin
            errors++;
            $display("Error at %0t: read miss made %0d l2 requests", $time, req_count - req_before);
        end
        req_before = req_count;
        cpu_access(1'b0, 32'h0000_0048, '0, cycles);
        if (cycles != 2 || req_count != req_before) begin
            errors++;
            $display("Error at %0t: hit took %0d cycles with %0d l2 requests",
                     $time, cycles, req_count - req_before);
        end

        // write hit, then every word of that line
        cpu_access(1'b1, 32'h0000_004C, 32'h1234_ABCD, cycles);
        for (int w = 0; w < 4; w++) begin
            cpu_access(1'b0, 32'h0000_0040 + 32'(4 * w), '0, cycles);
        end

        // set 9: dirty A is evicted by B and C
        wb_before = wb_count;
        cpu_access(1'b1, 32'h0000_1094, 32'hCAFE_0001, cycles);
        cpu_access(1'b0, 32'h0000_2090, '0, cycles);
        cpu_access(1'b0, 32'h0000_3090, '0, cycles);
        if (wb_count != wb_before + 1 || last_wb_addr !== 32'h0000_1090) begin
            errors++;
            $display("Error at %0t: %0d write-backs, last at %h, expected one at 00001090",
                     $time, wb_count - wb_before, last_wb_addr);
        end
        req_before = req_count;
        cpu_access(1'b0, 32'h0000_1094, '0, cycles);
        if (req_count == req_before) begin
            errors++;
            $display("Error at %0t: read of evicted line made no refill", $time);
        end

        // random traffic, 8 lines over sets 2 and 3
        for (int i = 0; i < 200; i++) begin
            rand_bits(2, r_tag);
            rand_bits(1, r_set);
            rand_bits(2, r_word);
            rand_bits(1, r_we);
            rand_bits(32, r_data);
            a = 32'h0000_8000 + (r_tag << 8) + ((r_set + 2) << 4) + (r_word << 2);
            cpu_access(r_we[0], a, r_data, cycles);
        end

        repeat (2) @(negedge clk);
        end_run();
    end

endmodule

/* tb_l2_model.sv */
module tb_l2_model (
    input  logic               clk,
    input  logic               l2_req,
    input  logic               l2_we,
    input  dcache_pkg::addr_t  l2_addr,
    input  dcache_pkg::line_t  l2_wdata,
    output dcache_pkg::line_t  l2_rdata,
    output logic               l2_ack,
    output int                 wb_count,
    output dcache_pkg::addr_t  last_wb_addr,
    output int                 model_errors
);

    localparam int RELEASE_LIMIT = 16;

    dcache_pkg::line_t mem [dcache_pkg::addr_t];   // only lines written back
    logic [31:0]       lfsr_state;

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    // one lfsr step per bit taken
    task automatic rand_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            v          = {v[30:0], lfsr_state[0]};
            lfsr_state = lfsr_next(lfsr_state);
        end
    endtask

    // each word holds its own address, 5a5a on top
    function automatic dcache_pkg::line_t read_line(input dcache_pkg::addr_t a);
        dcache_pkg::line_t l;
        dcache_pkg::addr_t wa;
        if (mem.exists(a)) begin
            return mem[a];
        end
        for (int w = 0; w < dcache_pkg::WORDS_PER_LINE; w++) begin
            wa             = a + dcache_pkg::addr_t'(4 * w);
            l[w*32 +: 32] = {16'h5A5A, wa[31:16] ^ wa[15:0]};
        end
        return l;
    endfunction

    initial begin
        logic [31:0]       d;
        int                n;
        logic              req_we;
        dcache_pkg::addr_t req_addr;
        dcache_pkg::line_t req_wdata;
        l2_ack       = 1'b0;
        l2_rdata     = '0;
        wb_count     = 0;
        last_wb_addr = '0;
        model_errors = 0;
        lfsr_state   = 32'ha476a1d7;
        forever begin
            @(negedge clk);
            if (l2_req && !l2_ack) begin
                req_we    = l2_we;
                req_addr  = l2_addr;
                req_wdata = l2_wdata;
                rand_bits(3, d);            // 0 to 7 cycles before ack
                repeat (d) @(negedge clk);
                if (req_we) begin
                    mem[req_addr] = req_wdata;
                    wb_count++;
                    last_wb_addr = req_addr;
                end else begin
                    l2_rdata = read_line(req_addr);
                end
                l2_ack = 1'b1;
                n = 0;
                while (l2_req && n < RELEASE_LIMIT) begin
                    @(negedge clk);
                    n++;
                end
                if (l2_req) begin
                    $display("l2 model gave up at %0t, l2_req stayed high after l2_ack", $time);
                    model_errors++;
                end
                rand_bits(2, d);            // 0 to 3 cycles before release
                repeat (d) @(negedge clk);
                l2_ack = 1'b0;
            end
        end
    end

endmodule
